//--- Makefile
VERILATOR  ?= verilator
TOP        := plic_tb
FILELIST   := plic_top.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --assert -j 0
OBJ_DIR    := obj_dir
PASS_MSG   := ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- common/plic_config.svh
// size settings shared by the PLIC RTL and its testbench
// sources count includes the unused source 0, so 31 real sources
// data width must be at least the source count (pending and enable are one word)

`ifndef PLIC_CONFIG_SVH
`define PLIC_CONFIG_SVH

// number of interrupt sources, source 0 tied off
`define PLIC_NUM_SRC 32

// number of target contexts
`define PLIC_NUM_CTX 4

// priority field width, 0 means never interrupt
`define PLIC_PRIO_W 4

`define PLIC_ADDR_W 22  // byte address
`define PLIC_DATA_W 32  // register bus word

`endif

//--- common/plic_ctx_if.sv
// one target context: configuration from the register file, arbitration result back
// claim is a single-cycle strobe, id and ip are registered in the target

`timescale 1ns/1ps
`default_nettype none

interface plic_ctx_if import plic_irq_pkg::*; ();

    src_vec_t enable;     // per-source enable of this context
    prio_t    threshold;  // only priorities above this interrupt
    logic     claim;      // claim read accepted for this context

    src_id_t  id;         // best pending source, 0 if none
    logic     ip;         // interrupt line to the core

    modport regs (
        output enable,
        output threshold,
        output claim,
        input  id
    );

    modport target (
        input  enable,
        input  threshold,
        input  claim,
        output id,
        output ip
    );

endinterface

`default_nettype wire

//--- common/plic_irq_pkg.sv
// interrupt-side types shared by gateway, targets and register file
// source id width follows the source count, which must be a power of two

`default_nettype none

`include "plic_config.svh"

package plic_irq_pkg;

    // one source priority
    typedef logic [`PLIC_PRIO_W-1:0] prio_t;

    // source number, 0 means no interrupt
    typedef logic [$clog2(`PLIC_NUM_SRC)-1:0] src_id_t;

    typedef logic [`PLIC_NUM_SRC-1:0] src_vec_t;  // one bit per source

    // priority of every source, indexed by source number
    typedef logic [`PLIC_NUM_SRC-1:0][`PLIC_PRIO_W-1:0] prio_arr_t;

endpackage

`default_nettype wire

//--- common/plic_reg_pkg.sv
// register map of the PLIC bus slave
// every register is one 32-bit word at a word-aligned byte address

`default_nettype none

`include "plic_config.svh"

package plic_reg_pkg;

    typedef logic [`PLIC_ADDR_W-1:0] addr_t;

    // which register block an address falls in
    typedef enum logic [2:0] {
        REG_PRIO,
        REG_PEND,
        REG_ENABLE,
        REG_THRESH,
        REG_CLAIM,
        REG_NONE
    } plic_region_e;

    localparam addr_t PRIO_BASE     = 'h000000;
    localparam addr_t PRIO_STRIDE   = 'h4;       // per source
    localparam addr_t PEND_BASE     = 'h001000;  // read only
    localparam addr_t ENABLE_BASE   = 'h002000;
    localparam addr_t ENABLE_STRIDE = 'h80;      // per context
    localparam addr_t CTX_BASE      = 'h200000;
    localparam addr_t CTX_STRIDE    = 'h1000;    // per context
    localparam addr_t THRESH_OFS    = 'h0;       // inside a context block
    localparam addr_t CLAIM_OFS     = 'h4;       // claim on read, complete on write

endpackage

`default_nettype wire

//--- dv/plic_tb.sv
// self-checking testbench for plic_top, LFSR stimulus against a reference model
// the model is compared only after 3 quiet cycles, so all fixed latencies have settled
// tasks start and end 1 ns after a rising clock edge

`timescale 1ns/1ps
`default_nettype none

`include "plic_config.svh"

module plic_tb import plic_irq_pkg::*, plic_reg_pkg::*; ();

    typedef logic [`PLIC_DATA_W-1:0] data_t;

    localparam int CLK_NS = 8;
    localparam int SETTLE = 3;
    // rough cycle counts of the five tests, doubled for the watchdog
    localparam int TEST_CYCLES = 150 + 200 + 520 + 200 + 260;
    localparam int WATCHDOG_NS = 2 * TEST_CYCLES * CLK_NS + 1000;

    localparam addr_t UNMAPPED [8] = '{22'h000080, 22'h000006, 22'h001004, 22'h002004,
                                       22'h002200, 22'h200008, 22'h204000, 22'h3ffffc};

    logic                     clk;
    logic                     nrst;
    src_vec_t                 irq;
    logic                     req_valid;
    logic                     req_write;
    addr_t                    req_addr;
    data_t                    req_wdata;
    logic                     rvalid;
    data_t                    rdata;
    logic [`PLIC_NUM_CTX-1:0] ip;

    // reference model state
    prio_t    m_prio [`PLIC_NUM_SRC];
    src_vec_t m_enable [`PLIC_NUM_CTX];
    prio_t    m_thresh [`PLIC_NUM_CTX];
    src_vec_t m_in_service;

    logic [31:0] lfsr_state = 32'h647d_c418;
    int checks = 0;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;

    plic_top uut (
        .i_clk       (clk),
        .i_nrst      (nrst),
        .i_irq       (irq),
        .i_req_valid (req_valid),
        .i_req_write (req_write),
        .i_req_addr  (req_addr),
        .i_req_wdata (req_wdata),
        .o_rvalid    (rvalid),
        .o_rdata     (rdata),
        .o_ip        (ip)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // fibonacci LFSR x^32 + x^22 + x^2 + x + 1, one step per returned bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    // zero a quarter of the time so some sources stay disabled
    function automatic data_t rand_prio();
        data_t p;
        p = '0;
        if (rand_bits(2) != 0) begin
            p = rand_bits(4);
        end
        return p;
    endfunction

    function automatic addr_t prio_addr(input int src);
        return PRIO_BASE + addr_t'(src) * PRIO_STRIDE;
    endfunction

    function automatic addr_t enable_addr(input int c);
        return ENABLE_BASE + addr_t'(c) * ENABLE_STRIDE;
    endfunction

    function automatic addr_t thresh_addr(input int c);
        return CTX_BASE + addr_t'(c) * CTX_STRIDE + THRESH_OFS;
    endfunction

    function automatic addr_t claim_addr(input int c);
        return CTX_BASE + addr_t'(c) * CTX_STRIDE + CLAIM_OFS;
    endfunction

    // level request, nonzero priority, not in service, source 0 never
    function automatic src_vec_t exp_pending();
        src_vec_t v;
        for (int i = 0; i < `PLIC_NUM_SRC; i++) begin
            v[i] = irq[i] && (m_prio[i] != 0) && !m_in_service[i];
        end
        v[0] = 1'b0;
        return v;
    endfunction

    // find the top qualifying priority, then the lowest source holding it
    function automatic src_id_t exp_winner(input int c);
        src_vec_t qual;
        prio_t    top;
        src_id_t  win;
        qual = exp_pending() & m_enable[c];
        top  = '0;
        win  = '0;
        for (int i = 1; i < `PLIC_NUM_SRC; i++) begin
            if (qual[i] && (m_prio[i] > m_thresh[c]) && (m_prio[i] > top)) begin
                top = m_prio[i];
            end
        end
        for (int i = `PLIC_NUM_SRC - 1; i >= 1; i--) begin
            if (qual[i] && (top != 0) && (m_prio[i] == top)) begin
                win = src_id_t'(i);
            end
        end
        return win;
    endfunction

    task automatic check_eq(input string what, input data_t got, input data_t exp);
        checks++;
        assert (got === exp) else begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic write_reg(input addr_t addr, input data_t data);
        req_valid = 1'b1;
        req_write = 1'b1;
        req_addr  = addr;
        req_wdata = data;
        idle(1);
        req_valid = 1'b0;
        checks++;
        assert (rvalid === 1'b0) else begin
            $display("a write to address %h gave a read-data pulse at %0t ns", addr, $time);
            errors++;
        end
    endtask

    task automatic read_reg(input addr_t addr, output data_t data);
        req_valid = 1'b1;
        req_write = 1'b0;
        req_addr  = addr;
        req_wdata = '0;
        idle(1);  // read data is due exactly one clock later
        req_valid = 1'b0;
        checks++;
        assert (rvalid === 1'b1) else begin
            $display("a read of address %h got no o_rvalid pulse at %0t ns", addr, $time);
            errors++;
        end
        data = rdata;
    endtask

    task automatic set_prio(input int src, input data_t data);
        write_reg(prio_addr(src), data);
        if (src != 0) begin
            m_prio[src] = data[`PLIC_PRIO_W-1:0];
        end
    endtask

    task automatic set_enable(input int c, input data_t data);
        write_reg(enable_addr(c), data);
        m_enable[c] = src_vec_t'(data);
    endtask

    task automatic set_thresh(input int c, input data_t data);
        write_reg(thresh_addr(c), data);
        m_thresh[c] = data[`PLIC_PRIO_W-1:0];
    endtask

    task automatic check_state(input string tag);
        data_t got;
        idle(SETTLE);
        read_reg(PEND_BASE, got);
        check_eq({tag, " pending"}, got, data_t'(exp_pending()));
        for (int c = 0; c < `PLIC_NUM_CTX; c++) begin
            check_eq($sformatf("%s o_ip[%0d]", tag, c), data_t'(ip[c]),
                     data_t'(exp_winner(c) != 0));
        end
    endtask

    // hands back the id that the DUT returned
    task automatic claim(input int c, output src_id_t taken);
        data_t   got;
        src_id_t win;
        idle(SETTLE);
        win = exp_winner(c);
        read_reg(claim_addr(c), got);
        check_eq($sformatf("claim of context %0d", c), got, data_t'(win));
        if (win != 0) begin
            m_in_service[win] = 1'b1;
        end
        taken = src_id_t'(got);
    endtask

    // ignored unless the id is enabled in that context
    task automatic complete(input int c, input src_id_t id);
        write_reg(claim_addr(c), data_t'(id));
        if ((id != 0) && m_enable[c][id]) begin
            m_in_service[id] = 1'b0;
        end
    endtask

    task automatic verify_all_regs();
        data_t got;
        for (int s = 0; s < `PLIC_NUM_SRC; s++) begin
            read_reg(prio_addr(s), got);
            check_eq($sformatf("priority %0d", s), got, data_t'(m_prio[s]));
        end
        for (int c = 0; c < `PLIC_NUM_CTX; c++) begin
            read_reg(enable_addr(c), got);
            check_eq($sformatf("enable %0d", c), got, data_t'(m_enable[c]));
            read_reg(thresh_addr(c), got);
            check_eq($sformatf("threshold %0d", c), got, data_t'(m_thresh[c]));
        end
    endtask

    task automatic report_test(input string name, input int err0, input int chk0);
        tests_run++;
        if (errors != err0) begin
            tests_failed++;
        end
        $display("%-16s %0d checks, %0d errors", name, checks - chk0, errors - err0);
    endtask

    task automatic readback_test();
        int    err0;
        int    chk0;
        int    sel;
        int    idx;
        data_t val;
        data_t got;
        err0 = errors;
        chk0 = checks;
        for (int k = 0; k < 40; k++) begin
            sel = int'(rand_bits(2));
            idx = int'(rand_bits(5));
            val = rand_bits(32);
            if (sel < 2) begin
                set_prio(idx, val);
                read_reg(prio_addr(idx), got);
                check_eq("priority readback", got, data_t'(m_prio[idx]));
            end else if (sel == 2) begin
                set_enable(idx % `PLIC_NUM_CTX, val);
                read_reg(enable_addr(idx % `PLIC_NUM_CTX), got);
                check_eq("enable readback", got, data_t'(m_enable[idx % `PLIC_NUM_CTX]));
            end else begin
                set_thresh(idx % `PLIC_NUM_CTX, val);
                read_reg(thresh_addr(idx % `PLIC_NUM_CTX), got);
                check_eq("threshold readback", got, data_t'(m_thresh[idx % `PLIC_NUM_CTX]));
            end
        end
        set_prio(0, 'hf);  // source 0 is tied off
        for (int k = 0; k < 8; k++) begin
            write_reg(UNMAPPED[k], rand_bits(32));
            read_reg(UNMAPPED[k], got);
            check_eq($sformatf("unmapped %h", UNMAPPED[k]), got, '0);
        end
        write_reg(PEND_BASE, rand_bits(32));
        verify_all_regs();
        check_state("readback");
        report_test("readback", err0, chk0);
    endtask

    task automatic pending_capture_test();
        int err0;
        int chk0;
        err0 = errors;
        chk0 = checks;
        for (int r = 0; r < 3; r++) begin
            for (int s = 1; s < `PLIC_NUM_SRC; s++) begin
                set_prio(s, rand_prio());
            end
            for (int k = 0; k < 8; k++) begin
                irq = rand_bits(32);
                check_state("capture");
            end
        end
        report_test("pending capture", err0, chk0);
    endtask

    task automatic arbitration_test();
        int      err0;
        int      chk0;
        src_id_t taken [`PLIC_NUM_CTX];
        err0 = errors;
        chk0 = checks;
        for (int r = 0; r < 6; r++) begin
            for (int s = 1; s < `PLIC_NUM_SRC; s++) begin
                set_prio(s, rand_prio());
            end
            for (int c = 0; c < `PLIC_NUM_CTX; c++) begin
                set_enable(c, rand_bits(32));
                set_thresh(c, rand_bits(2));  // low thresholds leave more winners
            end
            irq = rand_bits(32);
            check_state("arbitration");
            for (int c = 0; c < `PLIC_NUM_CTX; c++) begin
                claim(c, taken[c]);
                check_state("after claim");
            end
            for (int c = 0; c < `PLIC_NUM_CTX; c++) begin
                complete(c, taken[c]);
            end
            check_state("after complete");
        end
        report_test("arbitration", err0, chk0);
    endtask

    task automatic claim_complete_test();
        int      err0;
        int      chk0;
        int      s;
        data_t   bit_s;
        src_id_t taken;
        err0 = errors;
        chk0 = checks;
        for (int r = 0; r < 6; r++) begin
            s     = 1 + int'(rand_bits(5) % 31);
            bit_s = data_t'(1) << s;
            set_prio(s, rand_bits(4) % 15 + 1);
            set_enable(0, bit_s);                  // context 0 only sees s
            set_thresh(0, '0);
            set_enable(1, rand_bits(32) & ~bit_s); // context 1 never sees s
            irq = rand_bits(32) | bit_s;
            check_state("claim setup");
            claim(0, taken);
            check_eq("claimed source", data_t'(taken), data_t'(s));
            check_state("held in service");
            complete(1, src_id_t'(s));
            check_state("foreign complete");
            complete(0, src_id_t'(s));
            check_state("pends again");
        end
        report_test("claim/complete", err0, chk0);
    endtask

    task automatic threshold_test();
        int      err0;
        int      chk0;
        int      s;
        int      c;
        data_t   p;
        src_id_t taken;
        err0 = errors;
        chk0 = checks;
        for (int r = 0; r < 4; r++) begin
            s = 1 + int'(rand_bits(5) % 31);
            p = rand_bits(4) % 15 + 1;
            for (int i = 1; i < `PLIC_NUM_SRC; i++) begin
                set_prio(i, (i == s) ? p : '0);
            end
            for (int k = 0; k < `PLIC_NUM_CTX; k++) begin
                set_enable(k, '1);
                set_thresh(k, '0);
            end
            irq = rand_bits(32) | (data_t'(1) << s);
            check_state("threshold setup");
            c = int'(rand_bits(2));
            set_thresh(c, p + rand_bits(4) % (16 - p));  // at or above p
            check_state("raised threshold");
            claim(c, taken);
            claim((c + 1) % `PLIC_NUM_CTX, taken);
            check_eq("other context claim", data_t'(taken), data_t'(s));
            complete((c + 1) % `PLIC_NUM_CTX, taken);
            check_state("threshold restore");
        end
        report_test("threshold", err0, chk0);
    endtask

    initial begin
        nrst      = 1'b0;
        irq       = '0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        m_prio       = '{default: '0};
        m_enable     = '{default: '0};
        m_thresh     = '{default: '0};
        m_in_service = '0;
        idle(2);
        nrst = 1'b1;

        readback_test();
        pending_capture_test();
        arbitration_test();
        claim_complete_test();
        threshold_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- plic/plic_gateway.sv
// level-sensitive gateway, a source pends while its request is high
// claim and complete ids come from the register file, one strobe per cycle
// source 0 never pends and is never taken into service

`timescale 1ns/1ps
`default_nettype none

`include "plic_config.svh"

module plic_gateway import plic_irq_pkg::*; (
    input  wire logic    i_clk,
    input  wire logic    i_nrst,
    input  wire src_vec_t  i_irq,
    input  wire prio_arr_t i_prio,
    input  wire logic    i_claim_valid,
    input  wire src_id_t i_claim_id,
    input  wire logic    i_complete_valid,
    input  wire src_id_t i_complete_id,
    output src_vec_t     o_pending
);

    src_vec_t pending_q;
    src_vec_t in_service_q;
    src_vec_t eligible;      // request high with nonzero priority
    src_vec_t claim_vec;     // one-hot of the claimed source
    src_vec_t complete_vec;  // one-hot of the completed source

    always_comb begin
        claim_vec    = '0;
        complete_vec = '0;
        if (i_claim_valid) begin
            claim_vec[i_claim_id] = 1'b1;
        end
        if (i_complete_valid) begin
            complete_vec[i_complete_id] = 1'b1;
        end
        for (int i = 0; i < `PLIC_NUM_SRC; i++) begin
            eligible[i] = i_irq[i] && (i_prio[i] != '0);
        end
        eligible[0] = 1'b0;  // tied off
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            pending_q    <= '0;
            in_service_q <= '0;
        end else begin
            // a claimed source leaves pending at the same edge it enters service
            pending_q    <= eligible & ~in_service_q & ~claim_vec;
            in_service_q <= (in_service_q | claim_vec) & ~complete_vec;
        end
    end

    assign o_pending = pending_q;

    // register file only claims a context's nonzero winner
    a_claim_not_zero: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_claim_valid |-> (i_claim_id != '0));

    a_pend_excl_service: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (pending_q & in_service_q) == '0);

endmodule

`default_nettype wire

//--- plic/plic_regs.sv
// register bus slave, no stall, read data one cycle after the request
// unmapped addresses read 0 and ignore writes, pending is read only
// claim and complete strobes are combinational from the request cycle

`timescale 1ns/1ps
`default_nettype none

`include "plic_config.svh"

module plic_regs import plic_irq_pkg::*, plic_reg_pkg::*; (
    input  wire logic                     i_clk,
    input  wire logic                     i_nrst,
    input  wire logic                     i_req_valid,
    input  wire logic                     i_req_write,
    input  wire logic [`PLIC_ADDR_W-1:0]  i_req_addr,
    input  wire logic [`PLIC_DATA_W-1:0]  i_req_wdata,
    output logic                          o_rvalid,
    output logic [`PLIC_DATA_W-1:0]       o_rdata,
    input  wire src_vec_t                 i_pending,
    output prio_arr_t                     o_prio,
    output logic                          o_claim_valid,
    output src_id_t                       o_claim_id,
    output logic                          o_complete_valid,
    output src_id_t                       o_complete_id,
    plic_ctx_if.regs                      ctx [`PLIC_NUM_CTX]
);

    localparam int DATA_W    = `PLIC_DATA_W;
    localparam int CTX_IDX_W = $clog2(`PLIC_NUM_CTX);

    // block sizes of the map
    localparam addr_t PRIO_SPAN   = addr_t'(`PLIC_NUM_SRC * PRIO_STRIDE);
    localparam addr_t ENABLE_SPAN = addr_t'(`PLIC_NUM_CTX * ENABLE_STRIDE);
    localparam addr_t CTX_SPAN    = addr_t'(`PLIC_NUM_CTX * CTX_STRIDE);

    typedef logic [CTX_IDX_W-1:0] ctx_idx_t;

    plic_region_e region;
    src_id_t      src_sel;
    ctx_idx_t     ctx_sel;
    addr_t        prio_ofs;
    addr_t        en_ofs;
    addr_t        ctx_ofs;
    addr_t        ctx_word;  // offset inside one context block
    logic         wr_en;
    logic         rd_en;
    src_id_t      cmp_id;

    prio_arr_t    prio_q;
    src_vec_t     enable_q [`PLIC_NUM_CTX];
    prio_t        thresh_q [`PLIC_NUM_CTX];
    src_id_t      ctx_id   [`PLIC_NUM_CTX];
    logic [DATA_W-1:0] rdata_d;
    logic [DATA_W-1:0] rdata_q;
    logic         rvalid_q;

    assign wr_en = i_req_valid && i_req_write;
    assign rd_en = i_req_valid && !i_req_write;

    // offsets wrap below a base, so one compare checks both ends
    assign prio_ofs = i_req_addr - PRIO_BASE;
    assign en_ofs   = i_req_addr - ENABLE_BASE;
    assign ctx_ofs  = i_req_addr - CTX_BASE;
    assign ctx_word = ctx_ofs % CTX_STRIDE;

    always_comb begin
        region  = REG_NONE;
        src_sel = '0;
        ctx_sel = '0;
        if ((prio_ofs < PRIO_SPAN) && ((prio_ofs % PRIO_STRIDE) == '0)) begin
            region  = REG_PRIO;
            src_sel = src_id_t'(prio_ofs / PRIO_STRIDE);
        end else if (i_req_addr == PEND_BASE) begin
            region = REG_PEND;
        end else if ((en_ofs < ENABLE_SPAN) && ((en_ofs % ENABLE_STRIDE) == '0)) begin
            region  = REG_ENABLE;
            ctx_sel = ctx_idx_t'(en_ofs / ENABLE_STRIDE);
        end else if (ctx_ofs < CTX_SPAN) begin
            ctx_sel = ctx_idx_t'(ctx_ofs / CTX_STRIDE);
            if (ctx_word == THRESH_OFS) begin
                region = REG_THRESH;
            end else if (ctx_word == CLAIM_OFS) begin
                region = REG_CLAIM;
            end
        end
    end

    // configuration storage
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            prio_q <= '0;
            for (int c = 0; c < `PLIC_NUM_CTX; c++) begin
                enable_q[c] <= '0;
                thresh_q[c] <= '0;
            end
        end else if (wr_en) begin
            case (region)
                REG_PRIO: begin
                    if (src_sel != '0) begin  // source 0 stays at 0
                        prio_q[src_sel] <= i_req_wdata[`PLIC_PRIO_W-1:0];
                    end
                end
                REG_ENABLE: enable_q[ctx_sel] <= src_vec_t'(i_req_wdata);
                REG_THRESH: thresh_q[ctx_sel] <= i_req_wdata[`PLIC_PRIO_W-1:0];
                default: ;  // pending, complete and unmapped hold state here
            endcase
        end
    end

    always_comb begin
        case (region)
            REG_PRIO:   rdata_d = DATA_W'(prio_q[src_sel]);
            REG_PEND:   rdata_d = DATA_W'(i_pending);
            REG_ENABLE: rdata_d = DATA_W'(enable_q[ctx_sel]);
            REG_THRESH: rdata_d = DATA_W'(thresh_q[ctx_sel]);
            REG_CLAIM:  rdata_d = DATA_W'(ctx_id[ctx_sel]);
            default:    rdata_d = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= rd_en;
        end
    end

    always_ff @(posedge i_clk) begin
        if (rd_en) begin
            rdata_q <= rdata_d;
        end
    end

    assign o_rvalid = rvalid_q;
    assign o_rdata  = rdata_q;
    assign o_prio   = prio_q;

    // claim returns the context winner, an empty claim changes nothing
    assign o_claim_id    = ctx_id[ctx_sel];
    assign o_claim_valid = rd_en && (region == REG_CLAIM) && (o_claim_id != '0);

    // complete only for a source this context may have claimed
    assign cmp_id           = src_id_t'(i_req_wdata);
    assign o_complete_id    = cmp_id;
    assign o_complete_valid = wr_en && (region == REG_CLAIM) && (cmp_id != '0)
                              && enable_q[ctx_sel][cmp_id];

    for (genvar c = 0; c < `PLIC_NUM_CTX; c++) begin : g_ctx
        assign ctx_id[c]        = ctx[c].id;
        assign ctx[c].enable    = enable_q[c];
        assign ctx[c].threshold = thresh_q[c];
        assign ctx[c].claim     = o_claim_valid && (ctx_sel == ctx_idx_t'(c));
    end

    a_rvalid_after_read: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_rvalid |-> $past(rd_en));

    a_claim_complete_excl: assert property (@(posedge i_clk) disable iff (!i_nrst)
        !(o_claim_valid && o_complete_valid));

endmodule

`default_nettype wire

//--- plic/plic_target.sv
// arbitration for one context, result registered once
// highest priority above threshold wins, ties go to the lowest source number
// id and ip follow pending and config of the previous cycle, so a claimed
// source may still show for one cycle after the claim

`timescale 1ns/1ps
`default_nettype none

`include "plic_config.svh"

module plic_target import plic_irq_pkg::*; (
    input  wire logic      i_clk,
    input  wire logic      i_nrst,
    input  wire src_vec_t  i_pending,
    input  wire prio_arr_t i_prio,
    plic_ctx_if.target     ctx
);

    src_id_t best_id;
    prio_t   best_prio;
    src_id_t id_q;
    logic    ip_q;

    // linear scan, strict compare keeps the lower source on a tie
    always_comb begin
        best_id   = '0;
        best_prio = ctx.threshold;  // candidates must beat the threshold
        for (int i = 1; i < `PLIC_NUM_SRC; i++) begin
            if (i_pending[i] && ctx.enable[i] && (i_prio[i] > best_prio)) begin
                best_id   = src_id_t'(i);
                best_prio = i_prio[i];
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            id_q <= '0;
            ip_q <= 1'b0;
        end else begin
            id_q <= best_id;
            ip_q <= (best_id != '0);
        end
    end

    assign ctx.id = id_q;
    assign ctx.ip = ip_q;

    a_ip_matches_id: assert property (@(posedge i_clk) disable iff (!i_nrst)
        ctx.ip == (ctx.id != '0));

    // the winner was enabled when it was picked
    a_id_enabled: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (ctx.id != '0) |-> |(($past(ctx.enable) >> ctx.id) & src_vec_t'(1)));

    // register file claims only while this context is interrupting
    a_claim_when_ip: assert property (@(posedge i_clk) disable iff (!i_nrst)
        ctx.claim |-> ctx.ip);

endmodule

`default_nettype wire

//--- plic_top.f
+incdir+common
common/plic_irq_pkg.sv
common/plic_reg_pkg.sv
common/plic_ctx_if.sv
plic/plic_gateway.sv
plic/plic_target.sv
plic/plic_regs.sv
rtl/plic_top.sv
dv/plic_tb.sv

//--- rtl/plic_top.sv
// PLIC top level, plain register bus in place of a system bus bridge
// requests never stall, reads return one cycle later with o_rvalid
// i_irq[0] is ignored, sources are level sensitive only

`timescale 1ns/1ps
`default_nettype none

`include "plic_config.svh"

module plic_top import plic_irq_pkg::*; (
    input  wire logic                    i_clk,
    input  wire logic                    i_nrst,
    input  wire src_vec_t                i_irq,
    input  wire logic                    i_req_valid,
    input  wire logic                    i_req_write,
    input  wire logic [`PLIC_ADDR_W-1:0] i_req_addr,
    input  wire logic [`PLIC_DATA_W-1:0] i_req_wdata,
    output logic                         o_rvalid,
    output logic [`PLIC_DATA_W-1:0]      o_rdata,
    output logic [`PLIC_NUM_CTX-1:0]     o_ip
);

    prio_arr_t prio;            // shared by gateway and all targets
    src_vec_t  pending;
    logic      claim_valid;
    src_id_t   claim_id;
    logic      complete_valid;
    src_id_t   complete_id;

    plic_ctx_if ctx_if [`PLIC_NUM_CTX] ();

    plic_gateway u_gateway (
        .i_clk            (i_clk),
        .i_nrst           (i_nrst),
        .i_irq            (i_irq),
        .i_prio           (prio),
        .i_claim_valid    (claim_valid),
        .i_claim_id       (claim_id),
        .i_complete_valid (complete_valid),
        .i_complete_id    (complete_id),
        .o_pending        (pending)
    );

    plic_regs u_regs (
        .i_clk            (i_clk),
        .i_nrst           (i_nrst),
        .i_req_valid      (i_req_valid),
        .i_req_write      (i_req_write),
        .i_req_addr       (i_req_addr),
        .i_req_wdata      (i_req_wdata),
        .o_rvalid         (o_rvalid),
        .o_rdata          (o_rdata),
        .i_pending        (pending),
        .o_prio           (prio),
        .o_claim_valid    (claim_valid),
        .o_claim_id       (claim_id),
        .o_complete_valid (complete_valid),
        .o_complete_id    (complete_id),
        .ctx              (ctx_if)
    );

    for (genvar g = 0; g < `PLIC_NUM_CTX; g++) begin : g_target
        plic_target u_target (
            .i_clk     (i_clk),
            .i_nrst    (i_nrst),
            .i_pending (pending),
            .i_prio    (prio),
            .ctx       (ctx_if[g])
        );

        assign o_ip[g] = ctx_if[g].ip;  // one line per context
    end

endmodule

`default_nettype wire
